// ==== Makefile ====
# Verilator build and run of the Wishbone ring FIFO testbench

TOP := tb_wb_ring_fifo
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG), check the result"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f wb_ring_fifo.f -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/tb_clock_gen.sv ====
// Clock and reset source for the FIFO testbench
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // Full clock period in simulation time units
  localparam int period = 100;

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Reset is held through four rising edges and released on the fifth edge
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule : tb_clock_gen

// ==== verification/tb_wb_ring_fifo.sv ====
// Directed tests for the Wishbone ring FIFO against a queue model
module tb_wb_ring_fifo
  import wbfifo_pkg::*;
();

  // Bus accesses made by each test, in run order
  localparam int accesses_total = 2 + 14 + 15 + (8 * 6 + 1) + 22 + 12;
  // Each access takes three cycles, so four per access leaves slack
  localparam int watchdog_cycles = accesses_total * 4 + 20;
  localparam int ack_limit = 8;

  logic              clk;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [adr_w-1:0]  wb_adr;
  logic [data_w-1:0] wb_wdata;
  logic [data_w-1:0] wb_rdata;
  logic              wb_ack;

  // Reference model of the FIFO contents and the sticky overflow flag
  logic [data_w-1:0] model_q[$];
  logic              model_ovf;
  logic [31:0]       lfsr_state;
  string             cur_test;
  int                check_errors;
  int                test_errors;
  int                tests_run;
  int                tests_failed;

  tb_clock_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  wb_ring_fifo i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack)
  );

  // --------------------------------------------------------------------
  // Random words and bookkeeping
  // --------------------------------------------------------------------

  // Galois LFSR, one step per output bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'hb4bc_d35c;
    end
    return out;
  endfunction

  function automatic logic [data_w-1:0] rand_word();
    logic [data_w-1:0] w;
    for (int i = 0; i < data_w; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  task automatic note_error();
    check_errors++;
    test_errors++;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("[done] %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("[done] %s: %0d errors", cur_test, test_errors);
    end
  endtask

  // --------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------

  task automatic check_data(input string name, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: data expected %h, actual %h", name, exp, act);
      note_error();
    end
  endtask

  // Status layout is count in 2:0, empty in 4, full in 5 and overflow in 8
  task automatic check_status(input string name, input logic [cnt_w-1:0] exp_count,
                              input logic exp_empty, input logic exp_full,
                              input logic exp_ovf, input logic [data_w-1:0] act);
    logic [data_w-1:0] exp;
    exp = '0;
    exp[cnt_w-1:0] = exp_count;
    exp[4] = exp_empty;
    exp[5] = exp_full;
    exp[8] = exp_ovf;
    if (act !== exp) begin
      $display("FAILED %s: status expected %h, actual %h", name, exp, act);
      note_error();
    end
  endtask

  // --------------------------------------------------------------------
  // Bus tasks
  // --------------------------------------------------------------------

  // Drive on the rising edge, watch for ack on the falling edge
  task automatic bus_access(input logic we, input reg_addr_e adr,
                            input logic [data_w-1:0] wdata,
                            output logic [data_w-1:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_wdata <= wdata;
    @(negedge clk);
    while (!wb_ack && waited < ack_limit) begin
      @(negedge clk);
      waited++;
    end
    if (wb_ack) begin
      rdata = wb_rdata;
    end else begin
      $display("%s: DUT never raised ack on access to %s", cur_test, adr.name());
      note_error();
      rdata = '0;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input reg_addr_e adr, input logic [data_w-1:0] wdata);
    logic [data_w-1:0] unused;
    bus_access(1'b1, adr, wdata, unused);
  endtask

  task automatic wb_read(input reg_addr_e adr, output logic [data_w-1:0] rdata);
    bus_access(1'b0, adr, '0, rdata);
  endtask

  // --------------------------------------------------------------------
  // Model-backed operations
  // --------------------------------------------------------------------

  // A push into a full FIFO is lost and sets overflow
  task automatic push_word(input logic [data_w-1:0] w);
    wb_write(reg_data, w);
    if (model_q.size() < fifo_depth) begin
      model_q.push_back(w);
    end else begin
      model_ovf = 1'b1;
    end
  endtask

  // An empty FIFO reads as zero
  task automatic pop_and_check();
    logic [data_w-1:0] act;
    logic [data_w-1:0] exp;
    wb_read(reg_data, act);
    exp = '0;
    if (model_q.size() > 0) begin
      exp = model_q.pop_front();
    end
    check_data(cur_test, exp, act);
  endtask

  // Drop removes the smallest of the request, max_drop and the count
  task automatic drop_words(input int amount);
    int n;
    logic [data_w-1:0] gone;
    wb_write(reg_drop, data_w'(amount));
    n = amount;
    if (n > max_drop) n = max_drop;
    if (n > model_q.size()) n = model_q.size();
    repeat (n) gone = model_q.pop_front();
  endtask

  task automatic flush_fifo();
    wb_write(reg_flush, '0);
    model_q.delete();
    model_ovf = 1'b0;
  endtask

  task automatic status_matches_model();
    logic [data_w-1:0] act;
    wb_read(reg_status, act);
    check_status(cur_test, cnt_w'(model_q.size()), model_q.size() == 0,
                 model_q.size() == fifo_depth, model_ovf, act);
  endtask

  // --------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------

  task automatic test_reset_state();
    start_test("reset_state");
    status_matches_model();
    pop_and_check();
    end_test();
  endtask

  task automatic test_fill_drain();
    start_test("fill_drain");
    repeat (fifo_depth) push_word(rand_word());
    status_matches_model();
    repeat (fifo_depth) pop_and_check();
    status_matches_model();
    end_test();
  endtask

  task automatic test_overflow();
    start_test("overflow");
    repeat (fifo_depth + 1) push_word(rand_word());
    status_matches_model();
    repeat (fifo_depth) pop_and_check();
    status_matches_model();
    end_test();
  endtask

  // Three in and three out per round walks both pointers round the ring
  task automatic test_pointer_wrap();
    start_test("pointer_wrap");
    repeat (8) begin
      repeat (3) push_word(rand_word());
      repeat (3) pop_and_check();
    end
    status_matches_model();
    end_test();
  endtask

  task automatic test_drop();
    start_test("drop");
    repeat (fifo_depth) push_word(rand_word());
    drop_words(1);
    status_matches_model();
    drop_words(3);
    status_matches_model();
    // Refill so the next drops wrap the read pointer
    repeat (4) push_word(rand_word());
    drop_words(7);
    status_matches_model();
    drop_words(4);
    status_matches_model();
    repeat (2) push_word(rand_word());
    repeat (2) pop_and_check();
    end_test();
  endtask

  task automatic test_flush();
    start_test("flush");
    repeat (fifo_depth + 1) push_word(rand_word());
    flush_fifo();
    status_matches_model();
    push_word(rand_word());
    pop_and_check();
    status_matches_model();
    end_test();
  endtask

  // --------------------------------------------------------------------
  // Run control
  // --------------------------------------------------------------------

  initial begin
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_wdata = '0;
    lfsr_state = 32'hd262ab9e;
    model_ovf = 1'b0;
    check_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    wait (rst_n === 1'b1);
    test_reset_state();
    test_fill_drain();
    test_overflow();
    test_pointer_wrap();
    test_drop();
    test_flush();
    $display("tests run %0d, tests with errors %0d, check errors %0d",
             tests_run, tests_failed, check_errors);
    if (check_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule : tb_wb_ring_fifo

// ==== verilog/counter_incr.sv ====
// Wrapping counter that steps by a variable amount each cycle
//
// The counter wraps past fifo_depth-1 back to 0, which is not a power of two,
// so the wrap is done by an explicit subtraction instead of dropping carry bits
module counter_incr
  import wbfifo_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              reinit,
  input  logic [ptr_w-1:0]  initial_value,
  input  logic              incr_valid,
  input  logic [incr_w-1:0] incr,
  output logic [ptr_w-1:0]  value,
  output logic [ptr_w-1:0]  value_next
);

  // --------------------------------------------------------------------
  // Next value
  // --------------------------------------------------------------------

  // Start point of the step; reinit lets an increment apply to the initial value
  logic [ptr_w-1:0] base;
  // One extra bit holds the largest sum (fifo_depth-1 + max_drop)
  logic [ptr_w:0]   value_temp;
  // Sum with one full ring length taken off
  logic [ptr_w-1:0] value_wrapped;

  assign base = reinit ? initial_value : value;

  // An increment only counts when it is marked valid
  assign value_temp = {1'b0, base} + (incr_valid ? (ptr_w + 1)'(incr) : '0);

  // Since the step never exceeds one ring length, one subtraction is enough
  assign value_wrapped = ptr_w'(value_temp - (ptr_w + 1)'(fifo_depth));

  // Sums past the last entry fold back to the start of the ring
  assign value_next = (value_temp > (ptr_w + 1)'(fifo_depth - 1)) ?
                      value_wrapped : value_temp[ptr_w-1:0];

  // --------------------------------------------------------------------
  // State register
  // --------------------------------------------------------------------

  // Hold the value unless something asks it to move
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= '0;
    end else if (incr_valid || reinit) begin
      value <= value_next;
    end
  end

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------

  // The registered value never leaves the ring
  value_in_range_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    value < ptr_w'(fifo_depth)
  );

  // What value_next predicts is what the register holds one cycle later
  value_next_propagates_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> value == $past(value_next)
  );

  // A bare reinit lands exactly on the initial value
  reinit_no_incr_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    reinit && !incr_valid |=> value == $past(initial_value)
  );

endmodule : counter_incr

// ==== verilog/fifo_ctrl_if.sv ====
// Control and status link between the register block and the pointer logic
interface fifo_ctrl_if
  import wbfifo_pkg::*;
();

  // Requests from the register block, each lasting one cycle
  logic              push;
  logic [incr_w-1:0] pop_amount;
  logic              flush;

  // Occupancy and flags from the pointer side
  logic [cnt_w-1:0]  count;
  logic              full;
  logic              empty;
  logic              overflow;  // sticky until a flush

  // Register block side issues requests and watches status
  modport regs (
    output push, pop_amount, flush,
    input  count, full, empty, overflow
  );

  // Pointer side acts on requests and reports status
  modport ptr (
    input  push, pop_amount, flush,
    output count, full, empty, overflow
  );

endinterface : fifo_ctrl_if

// ==== verilog/ring_pointers.sv ====
// Read and write pointers of the ring, plus occupancy and flags
module ring_pointers
  import wbfifo_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  fifo_ctrl_if.ptr         ctrl,
  output logic [ptr_w-1:0] rd_ptr,
  output logic [ptr_w-1:0] wr_ptr,
  output logic             wr_en
);

  // Occupancy register
  logic [cnt_w-1:0] count_q;
  // Sticky flag for a push that found no room
  logic             overflow_q;
  // Read counter moves whenever some entries are popped
  logic             pop_valid;

  // --------------------------------------------------------------------
  // Push and pop qualification
  // --------------------------------------------------------------------

  // Full is only tested here; a push into a full ring is dropped silently
  assign wr_en = ctrl.push && !ctrl.full && !ctrl.flush;

  // The register block has already clamped the pop amount to the count
  assign pop_valid = (ctrl.pop_amount != '0) && !ctrl.flush;

  // --------------------------------------------------------------------
  // Pointers
  // --------------------------------------------------------------------

  // Write pointer steps by one per accepted push
  counter_incr i_wr_cnt (
    .clk           (clk),
    .rst_n         (rst_n),
    .reinit        (ctrl.flush),
    .initial_value ('0),
    .incr_valid    (wr_en),
    .incr          (incr_w'(1)),
    .value         (wr_ptr),
    .value_next    ()
  );

  // Read pointer steps by the pop amount, which may be up to max_drop
  counter_incr i_rd_cnt (
    .clk           (clk),
    .rst_n         (rst_n),
    .reinit        (ctrl.flush),
    .initial_value ('0),
    .incr_valid    (pop_valid),
    .incr          (ctrl.pop_amount),
    .value         (rd_ptr),
    .value_next    ()
  );

  // --------------------------------------------------------------------
  // Occupancy and flags
  // --------------------------------------------------------------------

  // Count follows the pointers on the same edge; flush clears everything
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else if (ctrl.flush) begin
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      count_q <= count_q + cnt_w'(wr_en) - cnt_w'(ctrl.pop_amount);
      // Remember a push that was thrown away
      if (ctrl.push && ctrl.full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  assign ctrl.count    = count_q;
  assign ctrl.full     = (count_q == cnt_w'(fifo_depth));
  assign ctrl.empty    = (count_q == '0);
  assign ctrl.overflow = overflow_q;

  // Occupancy never goes past the ring size
  count_in_range_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_q <= cnt_w'(fifo_depth)
  );

  // The two counters and the count agree: write leads read by count entries
  ptr_count_agree_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((int'(rd_ptr) + int'(count_q)) % fifo_depth) == int'(wr_ptr)
  );

endmodule : ring_pointers

// ==== verilog/ring_storage.sv ====
// Entry array of the ring
//
// One write port that lands at the clock edge and one read port
// that follows rd_ptr with no register in between
module ring_storage
  import wbfifo_pkg::*;
(
  input  logic              clk,
  input  logic              wr_en,
  input  logic [ptr_w-1:0]  wr_ptr,
  input  logic [data_w-1:0] wdata,
  input  logic [ptr_w-1:0]  rd_ptr,
  output logic [data_w-1:0] rdata
);

  // --------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------

  // The queued words sit in the entries from rd_ptr up to wr_ptr
  logic [data_w-1:0] mem [fifo_depth];

  // Write only accepted pushes; the pointer side has already checked for room
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // --------------------------------------------------------------------
  // Head word
  // --------------------------------------------------------------------

  // The oldest entry is always at the read pointer
  // The register block decides whether it is valid by looking at empty
  assign rdata = mem[rd_ptr];

endmodule : ring_storage

// ==== verilog/wb_fifo_regs.sv ====
// Wishbone classic slave that maps bus accesses onto FIFO requests
//
// Every access takes two cycles: the request is seen in idle, ack follows
// for one cycle, and then the slave rests in idle for at least one cycle
module wb_fifo_regs
  import wbfifo_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  reg_addr_e         wb_adr,
  input  logic [data_w-1:0] wb_wdata,
  output logic [data_w-1:0] wb_rdata,
  output logic              wb_ack,
  fifo_ctrl_if.regs         ctrl,
  input  logic [data_w-1:0] head,
  output logic [data_w-1:0] push_data
);

  wb_state_e         state;
  wb_state_e         state_nxt;
  // High for exactly one cycle per access, on the edge that raises ack
  logic              access;
  // Requested drop limited to max_drop, then to the current count
  logic [incr_w-1:0] drop_req;
  logic [incr_w-1:0] drop_amt;
  // Read data selected at access time and held through the ack cycle
  logic [data_w-1:0] rd_mux;
  logic [data_w-1:0] rdata_q;

  // --------------------------------------------------------------------
  // Bus handshake
  // --------------------------------------------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: if (wb_cyc && wb_stb) state_nxt = st_ack;
      st_ack:  state_nxt = st_idle;
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  assign access = (state == st_idle) && wb_cyc && wb_stb;
  assign wb_ack = (state == st_ack);

  // --------------------------------------------------------------------
  // Side effects
  // --------------------------------------------------------------------

  // Large requests are cut down to what one access may remove
  assign drop_req = (wb_wdata > data_w'(max_drop)) ? incr_w'(max_drop) : incr_w'(wb_wdata);
  // Never drop more than is stored, so the pointer side need not check
  assign drop_amt = (incr_w'(ctrl.count) < drop_req) ? incr_w'(ctrl.count) : drop_req;

  // Pushes are passed on even when full; the pointer side decides
  always_comb begin
    ctrl.push       = 1'b0;
    ctrl.pop_amount = '0;
    ctrl.flush      = 1'b0;
    if (access) begin
      if (wb_we) begin
        case (wb_adr)
          reg_data:  ctrl.push = 1'b1;
          reg_drop:  ctrl.pop_amount = drop_amt;
          reg_flush: ctrl.flush = 1'b1;
          default:   ctrl.push = 1'b0;
        endcase
      end else if (wb_adr == reg_data && !ctrl.empty) begin
        // A data read consumes the head word
        ctrl.pop_amount = incr_w'(1);
      end
    end
  end

  assign push_data = wb_wdata;

  // --------------------------------------------------------------------
  // Read data
  // --------------------------------------------------------------------

  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      reg_data: begin
        // An empty FIFO reads as zero rather than a stale entry
        if (!ctrl.empty) rd_mux = head;
      end
      reg_status: begin
        rd_mux[cnt_w-1:0] = ctrl.count;
        rd_mux[4]         = ctrl.empty;
        rd_mux[5]         = ctrl.full;
        rd_mux[8]         = ctrl.overflow;
      end
      default: rd_mux = '0;
    endcase
  end

  // Captured before the pop lands, so the popped word is what ack returns
  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= rd_mux;
    end
  end

  assign wb_rdata = rdata_q;

  // The master keeps its cycle open until it sees ack
  ack_in_cycle_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_ack |-> wb_cyc
  );

endmodule : wb_fifo_regs

// ==== verilog/wb_ring_fifo.sv ====
// Six-entry FIFO of 32-bit words behind a Wishbone classic slave port
module wb_ring_fifo
  import wbfifo_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [adr_w-1:0]  wb_adr,
  input  logic [data_w-1:0] wb_wdata,
  output logic [data_w-1:0] wb_rdata,
  output logic              wb_ack
);

  // --------------------------------------------------------------------
  // Internal links
  // --------------------------------------------------------------------

  // Requests and status between the register block and the pointers
  fifo_ctrl_if i_ctrl ();

  // Storage addressing comes straight from the pointer counters
  logic [ptr_w-1:0]  rd_ptr;
  logic [ptr_w-1:0]  wr_ptr;
  logic              wr_en;
  // Oldest stored word, and the word a push would store
  logic [data_w-1:0] head;
  logic [data_w-1:0] push_data;

  // --------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------

  // Bus decode; the raw address is read as a register map opcode
  wb_fifo_regs i_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (reg_addr_e'(wb_adr)),
    .wb_wdata  (wb_wdata),
    .wb_rdata  (wb_rdata),
    .wb_ack    (wb_ack),
    .ctrl      (i_ctrl.regs),
    .head      (head),
    .push_data (push_data)
  );

  // Pointer counters, occupancy and overflow tracking
  ring_pointers i_ptrs (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctrl   (i_ctrl.ptr),
    .rd_ptr (rd_ptr),
    .wr_ptr (wr_ptr),
    .wr_en  (wr_en)
  );

  // Entry array, written only for pushes that found room
  ring_storage i_mem (
    .clk    (clk),
    .wr_en  (wr_en),
    .wr_ptr (wr_ptr),
    .wdata  (push_data),
    .rd_ptr (rd_ptr),
    .rdata  (head)
  );

endmodule : wb_ring_fifo

// ==== verilog/wbfifo_pkg.sv ====
// Shared sizes and encodings for the Wishbone ring FIFO
package wbfifo_pkg;

  // --------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------

  // Number of entries in the ring, deliberately not a power of two
  localparam int fifo_depth = 6;

  // Width of one data word on the bus and in the storage array
  localparam int data_w = 32;

  // Pointer width covers entry indices 0 to fifo_depth-1
  localparam int ptr_w = 3;

  // Occupancy needs one more state than the pointers (0 to fifo_depth)
  localparam int cnt_w = 3;

  // Largest number of entries that one DROP access may discard
  localparam int max_drop = 4;

  // Width of an increment, wide enough to hold max_drop
  localparam int incr_w = 3;

  // Word address width of the slave port
  localparam int adr_w = 2;

  // --------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------

  // Register map, one opcode per word address
  typedef enum logic [adr_w-1:0] {
    reg_data   = 2'd0,  // write pushes, read pops
    reg_status = 2'd1,  // read only
    reg_drop   = 2'd2,  // write only
    reg_flush  = 2'd3   // write only
  } reg_addr_e;

  // Bus handshake state of the slave
  typedef enum logic [0:0] {
    st_idle = 1'b0,
    st_ack  = 1'b1
  } wb_state_e;

endpackage : wbfifo_pkg

// ==== wb_ring_fifo.f ====
verilog/wbfifo_pkg.sv
verilog/fifo_ctrl_if.sv
verilog/counter_incr.sv
verilog/ring_pointers.sv
verilog/ring_storage.sv
verilog/wb_fifo_regs.sv
verilog/wb_ring_fifo.sv
verification/tb_clock_gen.sv
verification/tb_wb_ring_fifo.sv
